/* compile.f */
logic/gpu_fb_pkg.sv
logic/pxl_gw.sv
logic/fb_bank_router.sv
logic/fb_bank.sv
logic/fb_rd_return.sv
logic/gpu_fb_top.sv
dv/gpu_fb_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = gpu_fb_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Result: PASSED

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/gpu_fb_tb.sv */
// Pixel gateway and frame buffer testbench: stimulus, reference memory and response checking
module gpu_fb_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import gpu_fb_pkg::*;

  typedef struct {
    int      due;                        // Cycle at which the response is sampled
    rd_rsp_t rsp;
  } exp_t;

  logic             cr_intf;
  logic             reset;
  pxl_req_t         core_req;
  pxl_req_t         aa_req;
  logic             scan_busy;
  logic             core_ready;
  logic             aa_ready;
  rd_rsp_t          rd_rsp;

  logic [pxl_w-1:0] ref_mem [int];       // Reference frame buffer, by linear address
  exp_t             exp_q [$];           // Outstanding reads in order
  rd_rsp_t          chk_rsp;             // Response due at the next edge
  logic             chk_vld;
  int               cyc;
  int               timeout_cycles;
  int               err_cnt;
  int               err_mark;            // Error count at start of test
  int               test_cnt;
  int               test_fail;
  logic [31:0]      lcg_state;

  gpu_fb_top UUT
  (
    .cr_intf    (cr_intf),
    .reset      (reset),
    .core_req   (core_req),
    .aa_req     (aa_req),
    .scan_busy  (scan_busy),
    .core_ready (core_ready),
    .aa_ready   (aa_ready),
    .rd_rsp     (rd_rsp)
  );

  initial
  begin
    cr_intf = 1'b0;
  end

  always #5 cr_intf = ~cr_intf;          // 100 MHz

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic in_canvas(input int col, input int row);
    return (col < canvas_w) && (row < canvas_h);
  endfunction

  function automatic int lin_addr(input int col, input int row);
    return row * canvas_w + col;         // Row-major canvas
  endfunction

  function automatic pxl_req_t mk_req(input logic wr, input logic rd, input int col,
                                      input int row, input logic [pxl_w-1:0] pix);
    pxl_req_t r;
    r.pixel    = pix;
    r.col      = pos_x_w'(col);
    r.row      = pos_y_w'(row);
    r.wr_valid = wr;
    r.rd_valid = rd;
    return r;
  endfunction

  // Reference model, follows every taken request
  always @(posedge cr_intf)
  begin
    pxl_req_t tk;
    exp_t     e;
    logic     hit;
    if (reset)
    begin
      exp_q.delete();
      chk_vld <= 1'b0;
      cyc = 0;
    end
    else
    begin
      cyc = cyc + 1;
      if (exp_q.size() > 0 && exp_q[0].due == cyc + 1)
      begin
        chk_rsp <= exp_q[0].rsp;         // Staged for next edge
        chk_vld <= 1'b1;
        exp_q.pop_front();
      end
      else
      begin
        chk_vld <= 1'b0;
      end
      hit = 1'b1;
      if ((core_req.wr_valid || core_req.rd_valid) && core_ready)
        tk = core_req;
      else if ((aa_req.wr_valid || aa_req.rd_valid) && aa_ready)
        tk = aa_req;
      else
        hit = 1'b0;
      if (hit && in_canvas(int'(tk.col), int'(tk.row)))
      begin
        if (tk.wr_valid)
          ref_mem[lin_addr(int'(tk.col), int'(tk.row))] = tk.pixel;
        if (tk.rd_valid)
        begin
          e.due       = cyc + 2;         // Fixed two-cycle read latency
          e.rsp.valid = 1'b1;
          e.rsp.pixel = ref_mem[lin_addr(int'(tk.col), int'(tk.row))];
          e.rsp.col   = tk.col;
          e.rsp.row   = tk.row;
          exp_q.push_back(e);
        end
      end
    end
  end

  a_core_ready : assert property (@(posedge cr_intf) disable iff (reset)
    core_ready == !scan_busy)
    else begin
      err_cnt = err_cnt + 1;
      $display("** Error: core_ready = %h, expected %h", core_ready, !scan_busy);
    end

  // Anti-alias held off whenever the core asks
  a_aa_ready : assert property (@(posedge cr_intf) disable iff (reset)
    aa_ready == (!scan_busy && !(core_req.wr_valid || core_req.rd_valid)))
    else begin
      err_cnt = err_cnt + 1;
      $display("** Error: aa_ready = %h, expected %h", aa_ready,
               !scan_busy && !(core_req.wr_valid || core_req.rd_valid));
    end

  a_rsp_due : assert property (@(posedge cr_intf) disable iff (reset)
    chk_vld |-> rd_rsp.valid)
    else begin
      err_cnt = err_cnt + 1;
      $display("Read response missing two cycles after the read was taken");
    end

  a_rsp_extra : assert property (@(posedge cr_intf) disable iff (reset)
    rd_rsp.valid |-> chk_vld)
    else begin
      err_cnt = err_cnt + 1;
      $display("Read response arrived with no read due");
    end

  a_rsp_pixel : assert property (@(posedge cr_intf) disable iff (reset)
    chk_vld |-> (rd_rsp.pixel == chk_rsp.pixel))
    else begin
      err_cnt = err_cnt + 1;
      $display("** Error: rd_rsp.pixel = %h, expected %h", rd_rsp.pixel, chk_rsp.pixel);
    end

  a_rsp_col : assert property (@(posedge cr_intf) disable iff (reset)
    chk_vld |-> (rd_rsp.col == chk_rsp.col))
    else begin
      err_cnt = err_cnt + 1;
      $display("** Error: rd_rsp.col = %h, expected %h", rd_rsp.col, chk_rsp.col);
    end

  a_rsp_row : assert property (@(posedge cr_intf) disable iff (reset)
    chk_vld |-> (rd_rsp.row == chk_rsp.row))
    else begin
      err_cnt = err_cnt + 1;
      $display("** Error: rd_rsp.row = %h, expected %h", rd_rsp.row, chk_rsp.row);
    end

  task automatic abort_run(input string what);
    $display("Timeout: %s", what);
    $display("Result: FAILED");
    $finish;
  endtask

  // Called 1 ns after an edge, returns 1 ns after the taking edge
  task automatic wait_take(input bit is_core);
    int   n;
    logic taken;
    n     = 0;
    taken = 1'b0;
    while (!taken && n < timeout_cycles)
    begin
      @(posedge cr_intf);
      if (is_core)
        taken = core_ready && (core_req.wr_valid || core_req.rd_valid);
      else
        taken = aa_ready && (aa_req.wr_valid || aa_req.rd_valid);
      n++;
    end
    if (!taken)
      abort_run("pixel request was never accepted");
    #1;
  endtask

  task automatic issue(input bit is_core, input pxl_req_t req);
    if (is_core)
      core_req = req;
    else
      aa_req = req;
    wait_take(is_core);
    if (is_core)
      core_req = '0;                     // Source lets go once taken
    else
      aa_req = '0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_q.size() > 0 || chk_vld) && n < timeout_cycles)
    begin
      @(posedge cr_intf);
      #1;
      n++;
    end
    if (exp_q.size() > 0 || chk_vld)
      abort_run("outstanding reads never drained");
  endtask

  task automatic report(input string name);
    test_cnt++;
    if (err_cnt != err_mark)
      test_fail++;
    $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  initial
  begin
    int               cols [16];
    int               rows [16];
    logic [pxl_w-1:0] pix;
    core_req       = '0;
    aa_req         = '0;
    scan_busy      = 1'b0;
    reset          = 1'b1;
    lcg_state      = 32'd93392;
    timeout_cycles = 200;
    err_cnt        = 0;
    err_mark       = 0;
    test_cnt       = 0;
    test_fail      = 0;
    repeat (4) @(posedge cr_intf);
    #1;
    reset = 1'b0;

    repeat (3) @(posedge cr_intf);       // Idle, readies follow scan_busy
    #1;
    report("reset state");

    for (int i = 0; i < 16; i++)
    begin
      cols[i] = int'((lcg_next() >> 8) % canvas_w);
      rows[i] = int'((lcg_next() >> 8) % canvas_h);
      pix     = pxl_w'(lcg_next() >> 4);
      issue(bit'(i % 2), mk_req(1'b1, 1'b0, cols[i], rows[i], pix));
    end
    for (int i = 0; i < 16; i++)
      issue(bit'((i + 1) % 2), mk_req(1'b0, 1'b1, cols[i], rows[i], '0));
    wait_drain();
    report("random write then read");

    // Both sources aim at one pixel, core first
    core_req = mk_req(1'b1, 1'b0, 320, 240, 24'h1111aa);
    aa_req   = mk_req(1'b1, 1'b0, 320, 240, 24'h2222bb);
    wait_take(1'b1);
    core_req = mk_req(1'b0, 1'b1, 320, 240, '0);   // Sees only the core write
    wait_take(1'b1);
    core_req = '0;
    wait_take(1'b0);                     // Anti-alias lands after core lets go
    aa_req = '0;
    issue(1'b1, mk_req(1'b0, 1'b1, 320, 240, '0));
    wait_drain();
    report("core priority");

    issue(1'b1, mk_req(1'b1, 1'b0, 60, 1, 24'h3c3c01));
    issue(1'b1, mk_req(1'b1, 1'b0, 700, 0, 24'hdead00));  // Same raw address, off canvas
    issue(1'b0, mk_req(1'b0, 1'b1, 700, 0, '0));          // No response expected
    issue(1'b0, mk_req(1'b0, 1'b1, 60, 1, '0));
    wait_drain();
    report("out of range drop");

    issue(1'b1, mk_req(1'b0, 1'b1, 320, 240, '0));
    scan_busy = 1'b1;                    // Read above still in flight
    core_req  = mk_req(1'b1, 1'b0, 10, 10, 24'h5a5a10);
    repeat (5) @(posedge cr_intf);
    #1;
    scan_busy = 1'b0;
    wait_take(1'b1);
    core_req = '0;
    issue(1'b1, mk_req(1'b0, 1'b1, 10, 10, '0));
    wait_drain();
    report("scan-out stall");

    for (int i = 0; i < 8; i++)
      issue(1'b0, mk_req(1'b1, 1'b0, 100 + i, 5, pxl_w'(24'h600000 + i * 24'h10203)));
    for (int i = 0; i < 8; i++)
      issue(1'b1, mk_req(1'b0, 1'b1, 100 + i, 5, '0));    // One per cycle, all banks
    wait_drain();
    report("back-to-back bank reads");

    $display("Tests %0d, failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
    if (err_cnt == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* logic/gpu_fb_top.sv */
// GPU frame buffer top: pixel gateway, bank router, four SRAM banks and read return
module gpu_fb_top
(
  input  logic                  cr_intf,
  input  logic                  reset,
  input  gpu_fb_pkg::pxl_req_t  core_req,
  input  gpu_fb_pkg::pxl_req_t  aa_req,
  input  logic                  scan_busy,   // Display scan-out owns the SRAM
  output logic                  core_ready,
  output logic                  aa_ready,
  output gpu_fb_pkg::rd_rsp_t   rd_rsp
);

  import gpu_fb_pkg::*;

  fb_acc_t    fb_acc;                   // Gateway to router
  logic       gpu_rdy;                  // Router back to gateway
  bank_req_t  bank_req [num_banks];     // Router to banks
  rd_rsp_t    bank_rsp [num_banks];     // Banks to return stage

  pxl_gw u_pxl_gw
  (
    .cr_intf    (cr_intf),
    .reset      (reset),
    .core_req   (core_req),
    .aa_req     (aa_req),
    .gpu_rdy    (gpu_rdy),
    .core_ready (core_ready),
    .aa_ready   (aa_ready),
    .fb_acc     (fb_acc)
  );

  fb_bank_router u_router
  (
    .cr_intf   (cr_intf),
    .reset     (reset),
    .fb_acc    (fb_acc),
    .scan_busy (scan_busy),
    .gpu_rdy   (gpu_rdy),
    .bank_req  (bank_req)
  );

  // One SRAM per interleave slot
  for (genvar g = 0; g < num_banks; g++)
  begin : g_bank
    fb_bank u_bank
    (
      .cr_intf  (cr_intf),
      .reset    (reset),
      .bank_req (bank_req[g]),
      .bank_rsp (bank_rsp[g])
    );
  end

  fb_rd_return u_rd_return
  (
    .cr_intf  (cr_intf),
    .reset    (reset),
    .bank_rsp (bank_rsp),
    .rd_rsp   (rd_rsp)          // Two cycles after the read is taken
  );

endmodule

/* logic/fb_rd_return.sv */
// Read return stage: picks the responding bank and registers its data and position
module fb_rd_return
(
  input  logic                  cr_intf,
  input  logic                  reset,
  input  gpu_fb_pkg::rd_rsp_t   bank_rsp [gpu_fb_pkg::num_banks],
  output gpu_fb_pkg::rd_rsp_t   rd_rsp
);

  import gpu_fb_pkg::*;

  rd_rsp_t              rsp_sel;    // Muxed bank response
  logic [num_banks-1:0] rsp_vld;    // Valid of each bank

  // One-hot pick; at most one bank answers per cycle
  always_comb
  begin
    rsp_sel = '0;
    for (int b = 0; b < num_banks; b++)
    begin
      rsp_vld[b] = bank_rsp[b].valid;
      if (bank_rsp[b].valid)
      begin
        rsp_sel = bank_rsp[b];
      end
    end
  end

  // Data and tag, only loaded on a hit
  always_ff @(posedge cr_intf)
  begin
    if (rsp_sel.valid)
    begin
      rd_rsp.pixel <= rsp_sel.pixel;
      rd_rsp.col   <= rsp_sel.col;
      rd_rsp.row   <= rsp_sel.row;
    end
  end

  // Valid clears on reset
  always_ff @(posedge cr_intf)
  begin
    if (reset)
    begin
      rd_rsp.valid <= 1'b0;
    end
    else
    begin
      rd_rsp.valid <= rsp_sel.valid;
    end
  end

  // Banks never answer together
  a_rsp_onehot : assert property (@(posedge cr_intf) disable iff (reset)
    $onehot0(rsp_vld));

endmodule

/* logic/fb_bank.sv */
// Frame buffer bank: single-port SRAM with registered read data and position tag
module fb_bank
(
  input  logic                   cr_intf,
  input  logic                   reset,
  input  gpu_fb_pkg::bank_req_t  bank_req,
  output gpu_fb_pkg::rd_rsp_t    bank_rsp   // One cycle after the read
);

  import gpu_fb_pkg::*;

  logic [pxl_w-1:0] mem [bank_depth];       // Pixel storage

  // Write port
  always_ff @(posedge cr_intf)
  begin
    if (bank_req.we)
    begin
      mem[bank_req.addr] <= bank_req.wdata;
    end
  end

  // Read data and tag
  always_ff @(posedge cr_intf)
  begin
    if (bank_req.re)
    begin
      bank_rsp.pixel <= mem[bank_req.addr];
      bank_rsp.col   <= bank_req.col;       // Position follows the data
      bank_rsp.row   <= bank_req.row;
    end
  end

  // Valid strobe, one pulse per read
  always_ff @(posedge cr_intf)
  begin
    if (reset)
    begin
      bank_rsp.valid <= 1'b0;
    end
    else
    begin
      bank_rsp.valid <= bank_req.re;
    end
  end

  // Single port: sources must not read and write in one request
  a_no_rw_collide : assert property (@(posedge cr_intf) disable iff (reset)
    !(bank_req.we && bank_req.re));

  // Address stays inside the bank
  a_addr_depth : assert property (@(posedge cr_intf) disable iff (reset)
    (bank_req.we || bank_req.re) |-> (bank_req.addr < bank_addr_w'(bank_depth)));

endmodule

/* logic/fb_bank_router.sv */
// Bank router that splits the address into bank and offset and steers enables under stall
module fb_bank_router
(
  input  logic                   cr_intf,
  input  logic                   reset,
  input  gpu_fb_pkg::fb_acc_t    fb_acc,
  input  logic                   scan_busy,   // Display controller owns the SRAM
  output logic                   gpu_rdy,
  output gpu_fb_pkg::bank_req_t  bank_req [gpu_fb_pkg::num_banks]
);

  import gpu_fb_pkg::*;

  logic [bank_sel_w-1:0]  bank_sel;     // Low address bits pick the bank
  logic [bank_addr_w-1:0] bank_addr;    // Remaining bits index inside it
  logic [num_banks-1:0]   bank_en;      // Per-bank activity, for checking
  logic                   issue_ok;

  // Scan-out is the only back-pressure
  assign gpu_rdy  = ~scan_busy;
  assign issue_ok = ~scan_busy;

  assign bank_sel  = fb_acc.addr[bank_sel_w-1:0];
  assign bank_addr = fb_acc.addr[fb_addr_w-1:bank_sel_w];

  always_comb
  begin
    for (int b = 0; b < num_banks; b++)
    begin
      // Payload fans out to every bank
      bank_req[b].addr  = bank_addr;
      bank_req[b].wdata = fb_acc.wdata;
      bank_req[b].col   = fb_acc.col;
      bank_req[b].row   = fb_acc.row;
      // Enables only to the addressed bank
      if (issue_ok && (bank_sel == bank_sel_w'(b)))
      begin
        bank_req[b].we = fb_acc.we;
        bank_req[b].re = fb_acc.re;
      end
      else
      begin
        bank_req[b].we = 1'b0;
        bank_req[b].re = 1'b0;
      end
      bank_en[b] = bank_req[b].we | bank_req[b].re;
    end
  end

  // One bank at most per cycle
  a_one_bank : assert property (@(posedge cr_intf) disable iff (reset)
    $onehot0(bank_en));

endmodule

/* logic/pxl_gw.sv */
// Pixel gateway picking core over anti-alias, bounds-checking the canvas and forming addresses
module pxl_gw
(
  input  logic                  cr_intf,
  input  logic                  reset,
  input  gpu_fb_pkg::pxl_req_t  core_req,   // GPU core, high priority
  input  gpu_fb_pkg::pxl_req_t  aa_req,     // Anti-alias engine
  input  logic                  gpu_rdy,    // Frame buffer can accept
  output logic                  core_ready,
  output logic                  aa_ready,
  output gpu_fb_pkg::fb_acc_t   fb_acc
);

  import gpu_fb_pkg::*;

  logic                   core_active;    // Core has a pending request
  logic                   core_in_range;
  logic                   aa_in_range;
  logic                   sel_in_range;
  pxl_req_t               sel_req;
  logic [fb_addr_w-7:0]   row_x10;        // Row times ten

  // Each source checked against its own position
  assign core_in_range = (core_req.col < pos_x_w'(canvas_w)) &
                         (core_req.row < pos_y_w'(canvas_h));
  assign aa_in_range   = (aa_req.col < pos_x_w'(canvas_w)) &
                         (aa_req.row < pos_y_w'(canvas_h));

  assign core_active = core_req.wr_valid | core_req.rd_valid;

  // Core always wins when it asks
  always_comb
  begin
    if (core_active)
    begin
      sel_req      = core_req;
      sel_in_range = core_in_range;
    end
    else
    begin
      sel_req      = aa_req;
      sel_in_range = aa_in_range;
    end
  end

  // Core ready tracks the bus; anti-alias is held off while the core requests
  assign core_ready = gpu_rdy;
  assign aa_ready   = gpu_rdy & ~core_active;

  // Address is row*640 + col where 640 is 10 << 6
  assign row_x10 = (fb_addr_w-6)'({sel_req.row, 3'd0}) +
                   (fb_addr_w-6)'({sel_req.row, 1'b0});

  always_comb
  begin
    fb_acc.addr  = {row_x10, 6'd0} + fb_addr_w'(sel_req.col);
    fb_acc.wdata = sel_req.pixel;
    fb_acc.we    = sel_req.wr_valid & sel_in_range;  // Off-canvas write is swallowed
    fb_acc.re    = sel_req.rd_valid & sel_in_range;  // Same for reads
    fb_acc.col   = sel_req.col;                      // Tag travels with the read
    fb_acc.row   = sel_req.row;
  end

  // Anything issued lands inside the canvas
  a_addr_in_canvas : assert property (@(posedge cr_intf) disable iff (reset)
    (fb_acc.we || fb_acc.re) |-> (fb_acc.addr < fb_addr_w'(canvas_w * canvas_h)));

endmodule

/* logic/gpu_fb_pkg.sv */
// GPU frame buffer package: canvas, bank and pixel constants plus request/response structs
package gpu_fb_pkg;

  // Canvas geometry, 640x480
  localparam int canvas_w    = 640;
  localparam int canvas_h    = 480;
  localparam int pos_x_w     = 10;     // Column position width
  localparam int pos_y_w     = 9;      // Row position width

  // Frame buffer organisation
  localparam int fb_addr_w   = 19;     // Linear address, 307,200 words
  localparam int pxl_w       = 24;     // RGB pixel word
  localparam int num_banks   = 4;      // Interleaved on addr[1:0]
  localparam int bank_sel_w  = 2;
  localparam int bank_depth  = 76800;  // Words per bank
  localparam int bank_addr_w = 17;

  // Request from a pixel source, 45 bits
  typedef struct packed {
    logic [pxl_w-1:0]   pixel;     // Write data
    logic [pos_x_w-1:0] col;
    logic [pos_y_w-1:0] row;
    logic               wr_valid;
    logic               rd_valid;
  } pxl_req_t;

  // Gateway access to the frame buffer, 64 bits
  typedef struct packed {
    logic [fb_addr_w-1:0] addr;    // row*640 + col
    logic [pxl_w-1:0]     wdata;
    logic                 we;
    logic                 re;
    logic [pos_x_w-1:0]   col;     // Position tag for the read return
    logic [pos_y_w-1:0]   row;
  } fb_acc_t;

  // Per-bank request, 62 bits
  typedef struct packed {
    logic [bank_addr_w-1:0] addr;  // Upper address bits only
    logic [pxl_w-1:0]       wdata;
    logic                   we;
    logic                   re;
    logic [pos_x_w-1:0]     col;
    logic [pos_y_w-1:0]     row;
  } bank_req_t;

  // Read data back to the requester, 44 bits
  typedef struct packed {
    logic               valid;
    logic [pxl_w-1:0]   pixel;
    logic [pos_x_w-1:0] col;
    logic [pos_y_w-1:0] row;
  } rd_rsp_t;

endpackage
